//--- common/telemetry_pkg.sv
package telemetry_pkg;

    // one byte on the serial line.
    parameter int BYTE_WIDTH = 8;

    // a sample is carried as two line bytes.
    parameter int SAMPLE_WIDTH = 2 * BYTE_WIDTH;

    // frame layout is sync, sync, hi, lo, end.
    parameter int FRAME_BYTES = 5;

    parameter logic [BYTE_WIDTH-1:0] SYNC_BYTE = 8'hFF;

    // newline closes every frame.
    parameter logic [BYTE_WIDTH-1:0] END_BYTE = 8'h0A;

    // byte position within a frame, 0 to FRAME_BYTES-1.
    typedef logic [2:0] frame_index_t;

    typedef struct packed {
        logic [BYTE_WIDTH-1:0] hi;
        logic [BYTE_WIDTH-1:0] lo;
    } sample_bytes_t;

    // same sample word, seen whole or as its two line bytes.
    typedef union packed {
        logic [SAMPLE_WIDTH-1:0] word;
        sample_bytes_t           bytes;
    } sample_t;

endpackage

//--- rtl/sample_framer.sv
`timescale 1ns/10ps

module sample_framer #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                                  i_clock,
    input  logic                                  i_reset,
    input  telemetry_pkg::sample_t                i_sample,
    input  logic                                  i_send,
    input  logic                                  i_credit_return,
    output logic                                  o_ready,
    output logic                                  o_push_valid,
    output logic [telemetry_pkg::BYTE_WIDTH-1:0]  o_push_data
);

    localparam int CREDIT_WIDTH = $clog2(FIFO_DEPTH + 1);
    localparam logic [CREDIT_WIDTH-1:0] FULL_CREDITS = CREDIT_WIDTH'(FIFO_DEPTH);
    localparam telemetry_pkg::frame_index_t LAST_INDEX =
        telemetry_pkg::frame_index_t'(telemetry_pkg::FRAME_BYTES - 1);

    telemetry_pkg::sample_t        sample_q;
    telemetry_pkg::frame_index_t   frame_index;
    logic [CREDIT_WIDTH-1:0]       credit_count;
    logic                          framing;
    logic                          accept;
    logic                          push;

    assign o_ready = ~framing;
    assign accept  = i_send & ~framing;

    // a push needs a free slot in the FIFO.
    assign push         = framing & (credit_count != '0);
    assign o_push_valid = push;

    // payload register, loaded on acceptance only.
    always_ff @(posedge i_clock) begin
        if (accept) begin
            sample_q.word <= i_sample.word;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            framing     <= 1'b0;
            frame_index <= '0;
        end else if (accept) begin
            framing     <= 1'b1;
            frame_index <= '0;
        end else if (push) begin
            if (frame_index == LAST_INDEX) begin
                framing     <= 1'b0;
                frame_index <= '0;
            end else begin
                frame_index <= frame_index + 3'd1;
            end
        end
    end

    // spend on push, refund on pop; both at once cancel out.
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            credit_count <= FULL_CREDITS;
        end else begin
            case ({push, i_credit_return})
                2'b10:   credit_count <= credit_count - 1'b1;
                2'b01:   credit_count <= credit_count + 1'b1;
                default: credit_count <= credit_count;
            endcase
        end
    end

    always_comb begin
        case (frame_index)
            3'd0, 3'd1: o_push_data = telemetry_pkg::SYNC_BYTE;
            3'd2:       o_push_data = sample_q.bytes.hi;
            3'd3:       o_push_data = sample_q.bytes.lo;
            default:    o_push_data = telemetry_pkg::END_BYTE;
        endcase
    end

endmodule

//--- rtl/byte_fifo.sv
`timescale 1ns/10ps

module byte_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                                  i_clock,
    input  logic                                  i_reset,
    input  logic                                  i_push_valid,
    input  logic [telemetry_pkg::BYTE_WIDTH-1:0]  i_push_data,
    input  logic                                  i_pop_ready,
    output logic                                  o_pop_valid,
    output logic [telemetry_pkg::BYTE_WIDTH-1:0]  o_pop_data,
    output logic                                  o_credit_return
);

    localparam int PTR_WIDTH   = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);
    localparam logic [PTR_WIDTH-1:0] LAST_SLOT = PTR_WIDTH'(FIFO_DEPTH - 1);

    logic [telemetry_pkg::BYTE_WIDTH-1:0] mem [FIFO_DEPTH];
    logic [PTR_WIDTH-1:0]                 wr_ptr;
    logic [PTR_WIDTH-1:0]                 rd_ptr;
    logic [COUNT_WIDTH-1:0]               count;
    logic                                 pop;

    assign o_pop_valid = (count != '0);
    assign o_pop_data  = mem[rd_ptr];
    assign pop         = o_pop_valid & i_pop_ready;

    // one credit back per byte leaving.
    assign o_credit_return = pop;

    // every write lands in a slot the producer holds a credit for.
    always_ff @(posedge i_clock) begin
        if (i_push_valid) begin
            mem[wr_ptr] <= i_push_data;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (i_push_valid) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            count <= '0;
        end else begin
            case ({i_push_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- uart/uart_tx.sv
`timescale 1ns/10ps

module uart_tx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic                                  i_clock,
    input  logic                                  i_reset,
    input  logic                                  i_data_valid,
    input  logic [telemetry_pkg::BYTE_WIDTH-1:0]  i_data,
    output logic                                  o_data_ready,
    output logic                                  o_tx,
    output logic                                  o_busy
);

    // start bit, data bits, stop bit.
    localparam int SHIFT_WIDTH = telemetry_pkg::BYTE_WIDTH + 2;
    localparam int CLK_WIDTH   = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam logic [CLK_WIDTH-1:0] LAST_CLK = CLK_WIDTH'(CLKS_PER_BIT - 1);
    localparam logic [3:0] LAST_BIT = 4'(SHIFT_WIDTH - 1);

    logic [SHIFT_WIDTH-1:0] shift_word;
    logic [CLK_WIDTH-1:0]   clk_count;
    logic [3:0]             bit_count;
    logic                   busy;
    logic                   load;
    logic                   bit_done;

    assign o_data_ready = ~busy;
    assign o_busy       = busy;
    assign load         = i_data_valid & ~busy;
    assign bit_done     = busy & (clk_count == LAST_CLK);

    // line bit is always the low end of the shift word.
    assign o_tx = shift_word[0];

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            busy <= 1'b0;
        end else if (load) begin
            busy <= 1'b1;
        end else if (bit_done && bit_count == LAST_BIT) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            clk_count <= '0;
            bit_count <= '0;
        end else if (load) begin
            clk_count <= '0;
            bit_count <= '0;
        end else if (busy) begin
            if (bit_done) begin
                clk_count <= '0;
                bit_count <= bit_count + 4'd1;
            end else begin
                clk_count <= clk_count + 1'b1;
            end
        end
    end

    // idle and stop leave ones behind, so the line rests high.
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            shift_word <= '1;
        end else if (load) begin
            shift_word <= {1'b1, i_data, 1'b0};
        end else if (bit_done && bit_count != LAST_BIT) begin
            shift_word <= {1'b1, shift_word[SHIFT_WIDTH-1:1]};
        end
    end

endmodule

//--- rtl/telemetry_tx_top.sv
`timescale 1ns/10ps

module telemetry_tx_top #(
    parameter int CLKS_PER_BIT = 16,
    parameter int FIFO_DEPTH   = 8
) (
    input  logic                                    i_clock,
    input  logic                                    i_reset,
    input  logic [telemetry_pkg::SAMPLE_WIDTH-1:0]  i_sample,
    input  logic                                    i_send,
    output logic                                    o_ready,
    output logic                                    o_tx,
    output logic                                    o_busy
);

    // framer to FIFO.
    logic                                 push_valid;
    logic [telemetry_pkg::BYTE_WIDTH-1:0] push_data;
    logic                                 credit_return;

    // FIFO to serializer.
    logic                                 pop_valid;
    logic [telemetry_pkg::BYTE_WIDTH-1:0] pop_data;
    logic                                 pop_ready;

    sample_framer #(
        .FIFO_DEPTH      (FIFO_DEPTH)
    ) u_framer (
        .i_clock         (i_clock),
        .i_reset         (i_reset),
        .i_sample        (i_sample),
        .i_send          (i_send),
        .i_credit_return (credit_return),
        .o_ready         (o_ready),
        .o_push_valid    (push_valid),
        .o_push_data     (push_data)
    );

    byte_fifo #(
        .FIFO_DEPTH      (FIFO_DEPTH)
    ) u_fifo (
        .i_clock         (i_clock),
        .i_reset         (i_reset),
        .i_push_valid    (push_valid),
        .i_push_data     (push_data),
        .i_pop_ready     (pop_ready),
        .o_pop_valid     (pop_valid),
        .o_pop_data      (pop_data),
        .o_credit_return (credit_return)
    );

    uart_tx #(
        .CLKS_PER_BIT    (CLKS_PER_BIT)
    ) u_uart_tx (
        .i_clock         (i_clock),
        .i_reset         (i_reset),
        .i_data_valid    (pop_valid),
        .i_data          (pop_data),
        .o_data_ready    (pop_ready),
        .o_tx            (o_tx),
        .o_busy          (o_busy)
    );

endmodule

//--- verification/telemetry_props.sv
`timescale 1ns/10ps

module telemetry_props #(
    parameter int FIFO_DEPTH = 8
) (
    input logic                                i_clock,
    input logic                                i_reset,
    input logic                                i_push_valid,
    input logic [$clog2(FIFO_DEPTH + 1)-1:0]   i_credit_count,
    input logic [$clog2(FIFO_DEPTH + 1)-1:0]   i_fifo_count,
    input logic                                i_ready,
    input logic                                i_tx,
    input logic                                i_busy
);

    credit_bounded: assert property (@(posedge i_clock) disable iff (i_reset)
        i_credit_count <= FIFO_DEPTH)
        else $error("framer credit count %0d above FIFO depth", i_credit_count);

    // a push always needs a credit in hand.
    push_has_credit: assert property (@(posedge i_clock) disable iff (i_reset)
        i_push_valid |-> (i_credit_count != '0))
        else $error("push issued with no credits left");

    credits_match_space: assert property (@(posedge i_clock) disable iff (i_reset)
        (i_fifo_count + i_credit_count) == FIFO_DEPTH)
        else $error("FIFO occupancy %0d plus credits %0d is not the FIFO depth",
            i_fifo_count, i_credit_count);

    line_idle_high: assert property (@(posedge i_clock) disable iff (i_reset)
        !i_busy |-> i_tx)
        else $error("serial line low while the transmitter is idle");

    idle_after_reset: assert property (@(posedge i_clock)
        $fell(i_reset) |-> (i_ready && i_tx))
        else $error("ready or line not high right after reset");

endmodule

bind telemetry_tx_top telemetry_props #(
    .FIFO_DEPTH     (FIFO_DEPTH)
) u_props (
    .i_clock        (i_clock),
    .i_reset        (i_reset),
    .i_push_valid   (push_valid),
    .i_credit_count (u_framer.credit_count),
    .i_fifo_count   (u_fifo.count),
    .i_ready        (o_ready),
    .i_tx           (o_tx),
    .i_busy         (o_busy)
);

//--- verification/telemetry_tb.sv
`timescale 1ns/10ps

module telemetry_tb;

    localparam int CLKS_PER_BIT  = 16;
    localparam int FIFO_DEPTH    = 8;
    localparam int HALF_BIT      = CLKS_PER_BIT / 2;
    localparam int BYTE_CYCLES   = 10 * CLKS_PER_BIT;
    localparam int LINE_TIMEOUT  = 40 * BYTE_CYCLES;
    localparam int READY_TIMEOUT = 40 * BYTE_CYCLES;
    localparam int SAMPLE_COUNT  = 10;

    logic        i_clock;
    logic        i_reset;
    logic [15:0] i_sample;
    logic        i_send;
    logic        o_ready;
    logic        o_tx;
    logic        o_busy;

    string       test_names [SAMPLE_COUNT];
    logic [15:0] samples [SAMPLE_COUNT];
    logic [7:0]  expected_q [$];
    integer      seed;
    int          value_errors;
    int          other_errors;
    int          waited;
    int          stall;

    telemetry_tx_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) i_dut (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_sample (i_sample),
        .i_send   (i_send),
        .o_ready  (o_ready),
        .o_tx     (o_tx),
        .o_busy   (o_busy)
    );

    initial begin
        i_clock = 1'b0;
        forever #5 i_clock = ~i_clock;
    end

    // frame is two syncs, high byte, low byte, newline.
    function automatic void append_frame(input logic [15:0] value);
        telemetry_pkg::sample_t      s;
        telemetry_pkg::frame_index_t idx;
        s.word = value;
        for (idx = 3'd0; idx <= 3'd4; idx = idx + 3'd1) begin
            if (idx < 3'd2) begin
                expected_q.push_back(8'hFF);
            end else if (idx == 3'd2) begin
                expected_q.push_back(s.bytes.hi);
            end else if (idx == 3'd3) begin
                expected_q.push_back(s.bytes.lo);
            end else begin
                expected_q.push_back(8'h0A);
            end
        end
    endfunction

    task automatic wait_ready(input string name, output int cycles);
        cycles = 0;
        @(posedge i_clock);
        while (o_ready !== 1'b1) begin
            if (cycles >= READY_TIMEOUT) begin
                $display("%s: timed out waiting for o_ready", name);
                other_errors++;
                return;
            end
            cycles++;
            @(posedge i_clock);
        end
    endtask

    // returns on the edge where the DUT takes the sample.
    task automatic send_sample(input string name, input logic [15:0] value, output int cycles);
        @(posedge i_clock);
        i_sample <= value;
        i_send   <= 1'b1;
        wait_ready(name, cycles);
        i_send   <= 1'b0;
    endtask

    task automatic decode_byte(input string name, output logic [7:0] data, output bit ok);
        logic [9:0] bits;
        int         timeout;
        int         busy_cycles;
        int         c;
        int         slot;
        logic       busy_end;
        ok = 1'b0;
        data = '0;
        bits = '0;
        timeout = 0;
        busy_cycles = 0;
        busy_end = 1'b1;
        @(posedge i_clock);
        while (o_tx !== 1'b0) begin
            if (timeout >= LINE_TIMEOUT) begin
                $display("%s: timed out waiting for a start bit on o_tx", name);
                other_errors++;
                return;
            end
            timeout++;
            @(posedge i_clock);
        end
        // this edge is the first cycle of the start bit.
        for (c = 1; c <= BYTE_CYCLES + 1; c++) begin
            if (c > 1) begin
                @(posedge i_clock);
            end
            if (c <= BYTE_CYCLES && o_busy === 1'b1) begin
                busy_cycles++;
            end
            if (c == BYTE_CYCLES + 1) begin
                busy_end = o_busy;
            end
            slot = (c - HALF_BIT) / CLKS_PER_BIT;
            if (c >= HALF_BIT && (c - HALF_BIT) % CLKS_PER_BIT == 0 && slot < 10) begin
                bits[slot] = o_tx;
            end
        end
        if (bits[0] !== 1'b0) begin
            $display("%s: start bit did not stay low to mid-period", name);
            other_errors++;
        end
        if (bits[9] !== 1'b1) begin
            $display("%s: stop bit was not high at mid-period", name);
            other_errors++;
        end
        if (busy_cycles != BYTE_CYCLES || busy_end !== 1'b0) begin
            $display("%s: o_busy was high for %0d cycles instead of %0d",
                name, busy_cycles, BYTE_CYCLES);
            other_errors++;
        end
        data = bits[8:1];
        ok = 1'b1;
    endtask

    task automatic check_bytes(input string name, input int count);
        logic [7:0] actual;
        logic [7:0] expected;
        bit         ok;
        int         k;
        for (k = 0; k < count; k++) begin
            decode_byte(name, actual, ok);
            if (!ok) begin
                return;
            end
            expected = expected_q.pop_front();
            if (actual !== expected) begin
                $display("ERROR %s: byte %0d expected %h actual %h", name, k, expected, actual);
                value_errors++;
            end
        end
    endtask

    // no start bit and no busy over the whole window.
    task automatic check_line_quiet(input string name, input int cycles);
        int c;
        for (c = 0; c < cycles; c++) begin
            @(posedge i_clock);
            if (o_tx !== 1'b1 || o_busy !== 1'b0) begin
                $display("%s: line became active after the frame ended", name);
                other_errors++;
                return;
            end
        end
    endtask

    initial begin
        seed = 32'h70f3;
        value_errors = 0;
        other_errors = 0;
        i_reset = 1'b1;
        i_send = 1'b0;
        i_sample = '0;
        test_names[0] = "zero";
        samples[0] = 16'h0000;
        test_names[1] = "count";
        samples[1] = 16'h1234;
        test_names[2] = "all_ones";
        samples[2] = 16'hFFFF;
        test_names[3] = "newlines";
        samples[3] = 16'h0A0A;
        test_names[4] = "alternate";
        samples[4] = 16'hA55A;
        test_names[5] = "low_ones";
        samples[5] = 16'h00FF;
        for (int r = 6; r < SAMPLE_COUNT; r++) begin
            test_names[r] = $sformatf("random_%0d", r - 6);
            samples[r] = 16'($random(seed));
        end

        repeat (4) @(posedge i_clock);
        i_reset <= 1'b0;
        @(posedge i_clock);
        if (o_ready !== 1'b1 || o_tx !== 1'b1 || o_busy !== 1'b0) begin
            $display("ERROR idle_after_reset: expected ready/tx/busy 110 actual %b%b%b",
                o_ready, o_tx, o_busy);
            value_errors++;
        end

        for (int i = 0; i < SAMPLE_COUNT; i++) begin
            expected_q.delete();
            append_frame(samples[i]);
            fork
                check_bytes(test_names[i], telemetry_pkg::FRAME_BYTES);
                send_sample(test_names[i], samples[i], waited);
            join
            if (waited != 0) begin
                $display("%s: o_ready was still low when the frame was sent", test_names[i]);
                other_errors++;
            end
        end

        // a second send during the frame must be dropped.
        expected_q.delete();
        append_frame(samples[1]);
        fork
            check_bytes("ignored_send", telemetry_pkg::FRAME_BYTES);
            begin
                send_sample("ignored_send", samples[1], waited);
                @(posedge i_clock);
                i_sample <= 16'hBEEF;
                i_send   <= 1'b1;
                @(posedge i_clock);
                if (o_ready !== 1'b0) begin
                    $display("ignored_send: o_ready was high while the frame was in progress");
                    other_errors++;
                end
                i_send   <= 1'b0;
            end
        join
        check_line_quiet("ignored_send", 3 * BYTE_CYCLES);

        // ten bytes overflow the FIFO credits, so ready must stall.
        expected_q.delete();
        append_frame(samples[2]);
        append_frame(samples[4]);
        fork
            check_bytes("back_pressure", 2 * telemetry_pkg::FRAME_BYTES);
            begin
                send_sample("back_pressure", samples[2], waited);
                send_sample("back_pressure", samples[4], waited);
                wait_ready("back_pressure", stall);
                if (stall <= telemetry_pkg::FRAME_BYTES) begin
                    $display("back_pressure: o_ready came back without a credit stall");
                    other_errors++;
                end
            end
        join
        check_line_quiet("back_pressure", 3 * BYTE_CYCLES);

        $display("checks done: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- files.f
common/telemetry_pkg.sv
rtl/sample_framer.sv
rtl/byte_fifo.sv
uart/uart_tx.sv
rtl/telemetry_tx_top.sv
verification/telemetry_props.sv
verification/telemetry_tb.sv

//--- Makefile
# Verilator flow for the telemetry transmitter.

TOP := telemetry_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f files.f \
		--top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG) || ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	verilator --lint-only --timing -Wall -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
